/* compile.f */
+incdir+.
ex_pkg.sv
ex_alu.sv
ex_mult.sv
ex_result_ctrl.sv
ex_wb_reg.sv
ex_stage.sv
tb_clk_gen.sv
tb_ex_stage.sv

/* ex_alu.sv */
`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_alu (
  input  ex_pkg::alu_req_t     alu_req_i,
  output logic [`EX_XLEN-1:0]  result_o,
  output logic                 cmp_result_o
);

  logic [`EX_XLEN-1:0]     op_a;
  logic [`EX_XLEN-1:0]     op_b;
  logic [`EX_SHAMT_W-1:0]  shamt;
  logic                    is_eq;
  logic                    is_lt;
  logic                    is_ltu;

  assign op_a  = alu_req_i.operand_a;
  assign op_b  = alu_req_i.operand_b;
  // Only the low bits of B count as shift amount
  assign shamt = op_b[`EX_SHAMT_W-1:0];

  ////////////////////
  // Shared comparators
  ////////////////////

  // One of each, used by SLT/SLTU and by the branch compares
  assign is_eq  = (op_a == op_b);
  assign is_lt  = ($signed(op_a) < $signed(op_b));
  assign is_ltu = (op_a < op_b);

  // Branch decision
  always_comb begin
    cmp_result_o = 1'b0;
    case (alu_req_i.operator)
      ex_pkg::ALU_EQ:  cmp_result_o = is_eq;
      ex_pkg::ALU_NE:  cmp_result_o = !is_eq;
      ex_pkg::ALU_LT:  cmp_result_o = is_lt;
      ex_pkg::ALU_GE:  cmp_result_o = !is_lt;
      ex_pkg::ALU_LTU: cmp_result_o = is_ltu;
      ex_pkg::ALU_GEU: cmp_result_o = !is_ltu;
      // Low for every non-compare operator
      default:         cmp_result_o = 1'b0;
    endcase
  end

  ////////////////////
  // Result mux
  ////////////////////

  always_comb begin
    result_o = '0;
    case (alu_req_i.operator)
      ex_pkg::ALU_ADD:  result_o = op_a + op_b;
      ex_pkg::ALU_SUB:  result_o = op_a - op_b;
      ex_pkg::ALU_AND:  result_o = op_a & op_b;
      ex_pkg::ALU_OR:   result_o = op_a | op_b;
      ex_pkg::ALU_XOR:  result_o = op_a ^ op_b;
      ex_pkg::ALU_SLL:  result_o = op_a << shamt;
      ex_pkg::ALU_SRL:  result_o = op_a >> shamt;
      // Arithmetic shift keeps the sign bit
      ex_pkg::ALU_SRA:  result_o = $unsigned($signed(op_a) >>> shamt);
      ex_pkg::ALU_SLT:  result_o = {{(`EX_XLEN-1){1'b0}}, is_lt};
      ex_pkg::ALU_SLTU: result_o = {{(`EX_XLEN-1){1'b0}}, is_ltu};
      // Branch compares return their decision as 0 or 1
      default:          result_o = {{(`EX_XLEN-1){1'b0}}, cmp_result_o};
    endcase
  end

endmodule

/* ex_macros.svh */
`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

// Integer datapath width
`define EX_XLEN 32

// Register file address width
// Six bits so the upper half can address extra register banks
`define EX_REG_ADDR_W 6

// Shift amount, taken from the low bits of operand B
`define EX_SHAMT_W 5

// MULH latency in cycles
// Counted from the issue cycle up to and including the result cycle
`define EX_MULH_CYCLES 3

`endif

/* ex_mult.sv */
`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_mult (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 enable_i,
  input  ex_pkg::mul_req_t     mul_req_i,
  input  logic                 ex_ready_i,
  output logic [`EX_XLEN-1:0]  result_o,
  output logic                 ready_o,
  output logic                 multicycle_o
);

  localparam int unsigned CNT_W = $clog2(`EX_MULH_CYCLES);

  // MULH sequence
  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    DONE
  } mulh_state_e;

  mulh_state_e                  state_q;
  mulh_state_e                  state_d;
  logic [CNT_W-1:0]             cnt_q;
  logic [CNT_W-1:0]             cnt_d;
  logic signed [2*`EX_XLEN-1:0] prod;
  logic [2*`EX_XLEN-1:0]        prod_q;
  logic                         mulh_start;

  // Full signed product, low word serves MUL directly
  assign prod = $signed(mul_req_i.operand_a) * $signed(mul_req_i.operand_b);

  // MULH issue, only accepted from idle
  assign mulh_start = enable_i && (mul_req_i.operator == ex_pkg::MUL_H) && (state_q == IDLE);

  ////////////////////
  // MULH FSM
  ////////////////////

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    case (state_q)
      IDLE: begin
        if (mulh_start) begin
          state_d = BUSY;
          // Issue cycle and done cycle are not counted here
          cnt_d   = CNT_W'(`EX_MULH_CYCLES - 2);
        end
      end
      BUSY: begin
        if (cnt_q == CNT_W'(1)) begin
          state_d = DONE;
        end else begin
          cnt_d = cnt_q - 1'b1;
        end
      end
      DONE: begin
        // Hold the high word until the stage moves on
        if (ex_ready_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // Product captured at issue
  always_ff @(posedge clk) begin
    if (mulh_start) begin
      prod_q <= prod;
    end
  end

  ////////////////////
  // Outputs
  ////////////////////

  // Stall from the issue cycle through the last busy cycle
  assign multicycle_o = mulh_start || (state_q == BUSY);
  assign ready_o      = !multicycle_o;
  assign result_o     = (state_q == DONE) ? prod_q[2*`EX_XLEN-1:`EX_XLEN] : prod[`EX_XLEN-1:0];

  // ID must hold the MULH request until it retires
  property p_mulh_req_stable;
    @(posedge clk) disable iff (!rst_n)
    (state_q != IDLE) |-> $stable(mul_req_i);
  endproperty

  a_mulh_req_stable: assert property (p_mulh_req_stable)
    else $error("MULH request changed while the multiplier was busy");

endmodule

/* ex_pkg.sv */
`include "ex_macros.svh"

package ex_pkg;

  // ALU operators
  // The last six are branch comparisons
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    ALU_EQ   = 4'd10,
    ALU_NE   = 4'd11,
    ALU_LT   = 4'd12,
    ALU_GE   = 4'd13,
    ALU_LTU  = 4'd14,
    ALU_GEU  = 4'd15
  } alu_op_e;

  // Multiplier operators, low word or signed high word
  typedef enum logic {
    MUL_L = 1'b0,
    MUL_H = 1'b1
  } mul_op_e;

  // ALU request from ID, 4 + 32 + 32 bits
  typedef struct packed {
    alu_op_e              operator;
    logic [`EX_XLEN-1:0]  operand_a;
    logic [`EX_XLEN-1:0]  operand_b;
  } alu_req_t;

  // Multiplier request from ID, 1 + 32 + 32 bits
  typedef struct packed {
    mul_op_e              operator;
    logic [`EX_XLEN-1:0]  operand_a;
    logic [`EX_XLEN-1:0]  operand_b;
  } mul_req_t;

  // Register file write port, 1 + 6 + 32 bits
  typedef struct packed {
    logic                       we;
    logic [`EX_REG_ADDR_W-1:0]  waddr;
    logic [`EX_XLEN-1:0]        wdata;
  } wb_port_t;

endpackage

/* ex_result_ctrl.sv */
`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_result_ctrl (
  input  logic                       alu_en_i,
  input  logic                       mult_en_i,
  input  logic                       csr_access_i,
  input  logic                       lsu_en_i,
  input  logic [`EX_XLEN-1:0]        alu_result_i,
  input  logic [`EX_XLEN-1:0]        mult_result_i,
  input  logic [`EX_XLEN-1:0]        csr_rdata_i,
  input  logic                       mult_ready_i,
  input  logic                       regfile_alu_we_i,
  input  logic [`EX_REG_ADDR_W-1:0]  regfile_alu_waddr_i,
  input  logic                       lsu_ready_ex_i,
  input  logic                       wb_ready_i,
  input  logic                       branch_in_ex_i,
  output ex_pkg::wb_port_t           fw_port_o,
  output logic                       ex_ready_o,
  output logic                       ex_valid_o
);

  logic [2:0] res_en;
  logic       units_ready;

  assign res_en = {csr_access_i, mult_en_i, alu_en_i};

  ////////////////////
  // Forwarding port
  ////////////////////

  always_comb begin
    fw_port_o.we    = regfile_alu_we_i;
    fw_port_o.waddr = regfile_alu_waddr_i;
    // CSR first, then multiplier, then ALU
    if (csr_access_i) begin
      fw_port_o.wdata = csr_rdata_i;
    end else if (mult_en_i) begin
      fw_port_o.wdata = mult_result_i;
    end else if (alu_en_i) begin
      fw_port_o.wdata = alu_result_i;
    end else begin
      fw_port_o.wdata = '0;
    end
    // Decode must never raise two result units at once
    if (!$isunknown(res_en)) begin
      a_res_en_onehot: assert final ($onehot0(res_en))
        else $error("More than one result unit enabled in EX");
    end
  end

  ////////////////////
  // Stage handshake
  ////////////////////

  // WB back-pressure and busy units stall the whole stage
  assign units_ready = mult_ready_i && lsu_ready_ex_i && wb_ready_i;

  // Branches finish in EX, so they free the stage regardless
  assign ex_ready_o  = units_ready || branch_in_ex_i;
  assign ex_valid_o  = (alu_en_i || mult_en_i || csr_access_i || lsu_en_i) && units_ready;

endmodule

/* ex_stage.sv */
`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_stage (
  input  logic                       clk,
  input  logic                       rst_n,
  // ALU request from ID
  input  logic                       alu_en_i,
  input  ex_pkg::alu_req_t           alu_req_i,
  input  logic [`EX_XLEN-1:0]        alu_operand_c_i,
  // Multiplier request from ID
  input  logic                       mult_en_i,
  input  ex_pkg::mul_req_t           mult_req_i,
  output logic                       mult_multicycle_o,
  // CSR read
  input  logic                       csr_access_i,
  input  logic [`EX_XLEN-1:0]        csr_rdata_i,
  // LSU side
  input  logic                       lsu_en_i,
  input  logic                       lsu_ready_ex_i,
  input  logic                       lsu_err_i,
  input  logic [`EX_XLEN-1:0]        lsu_rdata_i,
  // Destination registers
  input  logic                       branch_in_ex_i,
  input  logic                       regfile_alu_we_i,
  input  logic [`EX_REG_ADDR_W-1:0]  regfile_alu_waddr_i,
  input  logic                       regfile_we_i,
  input  logic [`EX_REG_ADDR_W-1:0]  regfile_waddr_i,
  // Write ports
  output ex_pkg::wb_port_t           fw_port_o,
  output ex_pkg::wb_port_t           wb_port_o,
  // To IF
  output logic                       branch_decision_o,
  output logic [`EX_XLEN-1:0]        jump_target_o,
  // Stage handshake
  output logic                       ex_ready_o,
  output logic                       ex_valid_o,
  input  logic                       wb_ready_i
);

  logic [`EX_XLEN-1:0]  alu_result;
  logic                 cmp_result;
  logic [`EX_XLEN-1:0]  mult_result;
  logic                 mult_ready;
  logic                 ex_ready;
  logic                 ex_valid;

  ////////////////////
  // Execute units
  ////////////////////

  ex_alu u_alu (
    .alu_req_i    (alu_req_i),
    .result_o     (alu_result),
    .cmp_result_o (cmp_result)
  );

  // Multiplier sees stage ready to release a finished MULH
  ex_mult u_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (mult_en_i),
    .mul_req_i    (mult_req_i),
    .ex_ready_i   (ex_ready),
    .result_o     (mult_result),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  ex_result_ctrl u_result_ctrl (
    .alu_en_i            (alu_en_i),
    .mult_en_i           (mult_en_i),
    .csr_access_i        (csr_access_i),
    .lsu_en_i            (lsu_en_i),
    .alu_result_i        (alu_result),
    .mult_result_i       (mult_result),
    .csr_rdata_i         (csr_rdata_i),
    .mult_ready_i        (mult_ready),
    .regfile_alu_we_i    (regfile_alu_we_i),
    .regfile_alu_waddr_i (regfile_alu_waddr_i),
    .lsu_ready_ex_i      (lsu_ready_ex_i),
    .wb_ready_i          (wb_ready_i),
    .branch_in_ex_i      (branch_in_ex_i),
    .fw_port_o           (fw_port_o),
    .ex_ready_o          (ex_ready),
    .ex_valid_o          (ex_valid)
  );

  ////////////////////
  // Second stage
  ////////////////////

  ex_wb_reg u_wb_reg (
    .clk             (clk),
    .rst_n           (rst_n),
    .ex_valid_i      (ex_valid),
    .wb_ready_i      (wb_ready_i),
    .regfile_we_i    (regfile_we_i),
    .regfile_waddr_i (regfile_waddr_i),
    .lsu_err_i       (lsu_err_i),
    .lsu_rdata_i     (lsu_rdata_i),
    .wb_port_o       (wb_port_o)
  );

  // Branch outcome and target straight back to IF
  assign branch_decision_o = cmp_result;
  assign jump_target_o     = alu_operand_c_i;

  assign ex_ready_o = ex_ready;
  assign ex_valid_o = ex_valid;

endmodule

/* ex_wb_reg.sv */
`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_wb_reg (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       ex_valid_i,
  input  logic                       wb_ready_i,
  input  logic                       regfile_we_i,
  input  logic [`EX_REG_ADDR_W-1:0]  regfile_waddr_i,
  input  logic                       lsu_err_i,
  input  logic [`EX_XLEN-1:0]        lsu_rdata_i,
  output ex_pkg::wb_port_t           wb_port_o
);

  logic                       we_q;
  logic [`EX_REG_ADDR_W-1:0]  waddr_q;
  logic                       load_we;

  // Errored load must not reach the register file
  assign load_we = regfile_we_i && !lsu_err_i;

  ////////////////////
  // EX/WB register
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_q <= 1'b0;
    end else if (ex_valid_i) begin
      // wb_ready is already folded into valid
      we_q <= load_we;
    end else if (wb_ready_i) begin
      // Bubble, flush the previous write
      we_q <= 1'b0;
    end
  end

  // Address only follows an instruction that will write
  always_ff @(posedge clk) begin
    if (ex_valid_i && load_we) begin
      waddr_q <= regfile_waddr_i;
    end
  end

  assign wb_port_o.we    = we_q;
  assign wb_port_o.waddr = waddr_q;
  // Load data arrives in the WB cycle itself
  assign wb_port_o.wdata = lsu_rdata_i;

  a_we_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(we_q))
    else $error("Load port write enable is unknown");

endmodule

/* tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned HALF_PERIOD  = 50,
  parameter int unsigned RESET_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_n_o
);

  // 100 ns clock
  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // Reset low from time zero until a rising edge
  initial begin
    rst_n_o <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

/* tb_ex_stage.sv */
`timescale 1ns/1ps
`include "ex_macros.svh"

module tb_ex_stage;

  logic clk;
  logic rst_n;
  logic alu_en_i;
  ex_pkg::alu_req_t alu_req_i;
  logic [`EX_XLEN-1:0] alu_operand_c_i;
  logic mult_en_i;
  ex_pkg::mul_req_t mult_req_i;
  logic mult_multicycle_o;
  logic csr_access_i;
  logic [`EX_XLEN-1:0] csr_rdata_i;
  logic lsu_en_i;
  logic lsu_ready_ex_i;
  logic lsu_err_i;
  logic [`EX_XLEN-1:0] lsu_rdata_i;
  logic branch_in_ex_i;
  logic regfile_alu_we_i;
  logic [`EX_REG_ADDR_W-1:0] regfile_alu_waddr_i;
  logic regfile_we_i;
  logic [`EX_REG_ADDR_W-1:0] regfile_waddr_i;
  ex_pkg::wb_port_t fw_port_o;
  ex_pkg::wb_port_t wb_port_o;
  logic branch_decision_o;
  logic [`EX_XLEN-1:0] jump_target_o;
  logic ex_ready_o;
  logic ex_valid_o;
  logic wb_ready_i;

  integer seed;
  int unsigned error_count;
  int unsigned timeout_count;
  int unsigned mulh_phase;
  logic mulh_stall;

  tb_clk_gen u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  ex_stage dut (.*);

  ////////////////////
  // Reference model
  ////////////////////

  // Reference branch compare
  // Low for every other operator
  function automatic logic branch_model(ex_pkg::alu_req_t req);
    logic [`EX_XLEN-1:0] a;
    logic [`EX_XLEN-1:0] b;
    a = req.operand_a;
    b = req.operand_b;
    case (req.operator)
      ex_pkg::ALU_EQ:  return a == b;
      ex_pkg::ALU_NE:  return a != b;
      ex_pkg::ALU_LT:  return $signed(a) < $signed(b);
      ex_pkg::ALU_GE:  return $signed(a) >= $signed(b);
      ex_pkg::ALU_LTU: return a < b;
      ex_pkg::ALU_GEU: return a >= b;
      default:         return 1'b0;
    endcase
  endfunction

  function automatic logic [`EX_XLEN-1:0] alu_model(ex_pkg::alu_req_t req);
    logic [`EX_XLEN-1:0] a;
    logic [`EX_XLEN-1:0] b;
    int unsigned sh;
    a  = req.operand_a;
    b  = req.operand_b;
    sh = b % `EX_XLEN;
    case (req.operator)
      ex_pkg::ALU_ADD:  return a + b;
      ex_pkg::ALU_SUB:  return a - b;
      ex_pkg::ALU_AND:  return a & b;
      ex_pkg::ALU_OR:   return a | b;
      ex_pkg::ALU_XOR:  return a ^ b;
      ex_pkg::ALU_SLL:  return a << sh;
      ex_pkg::ALU_SRL:  return a >> sh;
      ex_pkg::ALU_SRA:  return $signed(a) >>> sh;
      ex_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 1 : 0;
      ex_pkg::ALU_SLTU: return (a < b) ? 1 : 0;
      default:          return branch_model(req) ? 1 : 0;
    endcase
  endfunction

  // High word of the signed 64-bit product
  function automatic logic [`EX_XLEN-1:0] mulh_model(logic [`EX_XLEN-1:0] a,
                                                     logic [`EX_XLEN-1:0] b);
    longint p;
    p = longint'($signed(a)) * longint'($signed(b));
    return p[63:32];
  endfunction

  // Expected MULH progress, counted from the issue cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mulh_phase <= 0;
    end else if (!mult_en_i || mult_req_i.operator != ex_pkg::MUL_H) begin
      mulh_phase <= 0;
    end else if (mulh_phase < `EX_MULH_CYCLES - 1) begin
      mulh_phase <= mulh_phase + 1;
    end else if ((lsu_ready_ex_i && wb_ready_i) || branch_in_ex_i) begin
      // Retires once the stage is ready in the result cycle
      mulh_phase <= 0;
    end
  end

  // Issue cycle and busy cycle stall the stage
  assign mulh_stall = mult_en_i && (mult_req_i.operator == ex_pkg::MUL_H)
                      && (mulh_phase < `EX_MULH_CYCLES - 1);

  task automatic report_error(input string msg);
    error_count++;
    $display("** Error at %0t ns: %s", $time, msg);
  endtask

  ////////////////////
  // Checks
  ////////////////////

  a_alu: assert property (@(posedge clk) disable iff (!rst_n)
    (alu_en_i && !mult_en_i && !csr_access_i) |-> (fw_port_o.wdata == alu_model(alu_req_i)
      && fw_port_o.we == regfile_alu_we_i && fw_port_o.waddr == regfile_alu_waddr_i))
    else report_error($sformatf("ALU op %0d gave %h", alu_req_i.operator, fw_port_o.wdata));

  a_branch: assert property (@(posedge clk) disable iff (!rst_n)
    branch_decision_o == branch_model(alu_req_i) && jump_target_o == alu_operand_c_i)
    else report_error("branch decision or jump target mismatch");

  a_mul: assert property (@(posedge clk) disable iff (!rst_n)
    (mult_en_i && mult_req_i.operator == ex_pkg::MUL_L)
      |-> fw_port_o.wdata == mult_req_i.operand_a * mult_req_i.operand_b)
    else report_error($sformatf("MUL low word %h", fw_port_o.wdata));

  // Two stall cycles before the high word comes with valid
  a_mulh: assert property (@(posedge clk) disable iff (!rst_n)
    (mulh_stall && mulh_phase == 0) |-> (mult_multicycle_o && !ex_ready_o && !ex_valid_o) [*2]
      ##1 (!mult_multicycle_o && ex_valid_o
      && fw_port_o.wdata == mulh_model(mult_req_i.operand_a, mult_req_i.operand_b)))
    else report_error("MULH timing or high word mismatch");

  a_csr: assert property (@(posedge clk) disable iff (!rst_n)
    csr_access_i |-> fw_port_o.wdata == csr_rdata_i)
    else report_error("CSR read data not forwarded");

  a_ready_valid: assert property (@(posedge clk) disable iff (!rst_n)
    mult_multicycle_o == mulh_stall
    && ex_ready_o == ((!mulh_stall && lsu_ready_ex_i && wb_ready_i) || branch_in_ex_i)
    && ex_valid_o == ((alu_en_i || mult_en_i || csr_access_i || lsu_en_i)
      && !mulh_stall && lsu_ready_ex_i && wb_ready_i))
    else report_error("ex_ready_o, ex_valid_o or mult_multicycle_o mismatch");

  a_load_we: assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid_o |=> wb_port_o.we == $past(regfile_we_i && !lsu_err_i))
    else report_error("load port we wrong after valid");

  a_load_addr: assert property (@(posedge clk) disable iff (!rst_n)
    (ex_valid_o && regfile_we_i && !lsu_err_i) |=> wb_port_o.waddr == $past(regfile_waddr_i))
    else report_error("load port waddr not sampled");

  a_load_data: assert property (@(posedge clk) disable iff (!rst_n)
    wb_port_o.wdata == lsu_rdata_i)
    else report_error("load port wdata differs from lsu_rdata_i");

  a_bubble: assert property (@(posedge clk) disable iff (!rst_n)
    (!ex_valid_o && wb_ready_i) |=> !wb_port_o.we)
    else report_error("load port we not cleared on bubble");

  // Back-pressure freezes the EX/WB register
  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    !wb_ready_i |=> $stable(wb_port_o.we) && $stable(wb_port_o.waddr))
    else report_error("load port changed under back-pressure");

  a_reset: assert property (@(posedge clk) !rst_n |-> !wb_port_o.we && !mult_multicycle_o)
    else report_error("outputs active during reset");

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic wait_cycles_for(input logic is_valid, input int unsigned limit,
                                 input string what);
    int unsigned n;
    logic found;
    n     = 0;
    found = 1'b0;
    while (!found && n < limit) begin
      @(negedge clk);
      found = is_valid ? ex_valid_o : rst_n;
      n++;
    end
    if (!found) begin
      timeout_count++;
      $display("Timeout: %s did not happen within %0d cycles", what, limit);
    end
  endtask

  // Every drive starts on a rising edge with all units idle
  task automatic drive_idle();
    @(posedge clk);
    alu_en_i       <= 1'b0;
    mult_en_i      <= 1'b0;
    csr_access_i   <= 1'b0;
    lsu_en_i       <= 1'b0;
    branch_in_ex_i <= 1'b0;
    lsu_rdata_i    <= $random(seed);
    alu_operand_c_i <= $random(seed);
  endtask

  task automatic run_mult(input ex_pkg::mul_op_e op);
    drive_idle();
    mult_en_i  <= 1'b1;
    mult_req_i <= '{operator: op, operand_a: $random(seed), operand_b: $random(seed)};
    if (op == ex_pkg::MUL_H) begin
      wait_cycles_for(1'b1, `EX_MULH_CYCLES + 3, "MULH result");
    end
  endtask

  task automatic run_load(input logic we, input logic err);
    drive_idle();
    lsu_en_i        <= 1'b1;
    regfile_we_i    <= we;
    lsu_err_i       <= err;
    regfile_waddr_i <= $random(seed);
  endtask

  initial begin
    ex_pkg::alu_req_t req;
    seed = 32'h4287d8d0;
    error_count = 0;
    timeout_count = 0;
    {alu_en_i, mult_en_i, csr_access_i, lsu_en_i, lsu_err_i, branch_in_ex_i} = '0;
    {regfile_alu_we_i, regfile_we_i, regfile_alu_waddr_i, regfile_waddr_i} = '0;
    alu_req_i = '0;
    mult_req_i = '0;
    {alu_operand_c_i, csr_rdata_i, lsu_rdata_i} = '0;
    lsu_ready_ex_i = 1'b1;
    wb_ready_i = 1'b1;
    wait_cycles_for(1'b0, 20, "reset release");

    // Every ALU operator with equal operands on the first pass for the compares
    for (int op = 0; op < 16; op++) begin
      for (int k = 0; k < 6; k++) begin
        req.operator  = ex_pkg::alu_op_e'(op);
        req.operand_a = $random(seed);
        req.operand_b = (k == 0) ? req.operand_a : $random(seed);
        drive_idle();
        alu_en_i            <= 1'b1;
        alu_req_i           <= req;
        branch_in_ex_i      <= (op >= ex_pkg::ALU_EQ);
        regfile_alu_we_i    <= $random(seed);
        regfile_alu_waddr_i <= $random(seed);
      end
    end

    for (int k = 0; k < 4; k++) begin
      run_mult(ex_pkg::MUL_L);
      run_mult(ex_pkg::MUL_H);
    end

    for (int k = 0; k < 4; k++) begin
      drive_idle();
      csr_access_i <= 1'b1;
      csr_rdata_i  <= $random(seed);
    end

    // Known load address first and then random enables and errors
    run_load(1'b1, 1'b0);
    for (int k = 0; k < 6; k++) begin
      run_load($random(seed), $random(seed));
    end
    drive_idle();
    run_load(1'b1, 1'b0);
    for (int k = 0; k < 4; k++) begin
      run_load($random(seed), 1'b0);
      wb_ready_i     <= 1'b0;
      branch_in_ex_i <= k[0];
    end
    drive_idle();
    wb_ready_i <= 1'b1;
    // LSU stall with WB ready drops valid and clears the load port
    for (int k = 0; k < 2; k++) begin
      run_load(1'b1, 1'b0);
      lsu_ready_ex_i <= 1'b0;
      branch_in_ex_i <= k[0];
    end
    drive_idle();
    lsu_ready_ex_i <= 1'b1;
    repeat (3) drive_idle();

    $display("Checks finished: %0d assertion errors, %0d timeouts", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule
